//--- logic/saturn_cpu_pkg.sv
// Types taken from the CPU core when a register snapshot is captured
package saturn_cpu_pkg;

    // Saturn addresses are 20 bits wide, shown as five hex digits
    localparam int PC_W = 20;

    // The CPU works on 4-bit nibbles throughout
    localparam int NIBBLE_W = 4;

    // Number of hex digits printed for the PC field
    localparam int PC_NIBBLES = PC_W / NIBBLE_W;

    // Program counter as seen on the core's fetch side
    typedef logic [PC_W-1:0] pc_t;

    // One digit of any register
    typedef logic [NIBBLE_W-1:0] nibble_t;

endpackage : saturn_cpu_pkg

//--- logic/dbg_text_pkg.sv
// Text buffer types and character constants for the debug console
package dbg_text_pkg;

    localparam int DBG_ADDR_W = 9;                     // Top bit picks the bank

    typedef logic [7:0]            char_t;             // Plain ASCII
    typedef logic [DBG_ADDR_W-1:0] buf_addr_t;         // {bank, position}
    typedef logic [7:0]            line_len_t;         // Characters within one bank

    // Fixed parts of the dump line
    localparam int PC_LABEL_LEN    = 4;                // "PC: "
    localparam int CARRY_FIELD_LEN = 9;                // "Carry: x "

    localparam char_t CH_SPACE   = 8'h20;
    localparam char_t CH_COLON   = 8'h3a;
    localparam char_t CH_DIGIT_0 = 8'h30;              // Base for 0..9
    localparam char_t CH_HEX_A   = 8'h41;              // Base for A..F, upper case
    localparam char_t CH_P_UP    = 8'h50;
    localparam char_t CH_C_UP    = 8'h43;
    localparam char_t CH_A_LO    = 8'h61;
    localparam char_t CH_R_LO    = 8'h72;
    localparam char_t CH_Y_LO    = 8'h79;

    // Formatter sequencing, one state per field of the line
    typedef enum logic [2:0] {
        FMT_IDLE,
        FMT_PC_LABEL,
        FMT_PC_DIGITS,
        FMT_PAD,
        FMT_CARRY,
        FMT_DONE
    } fmt_state_t;

endpackage : dbg_text_pkg

//--- logic/dbg_mem_if.sv
// Single-port access to the text buffer
// Requester holds req and its fields until gnt, read data follows a cycle later
interface dbg_mem_if import dbg_text_pkg::*; ();

    logic      req;        // Access wanted
    logic      we;         // 1 = write, 0 = read
    buf_addr_t addr;
    char_t     wdata;
    logic      gnt;        // Access happens when req and gnt are both high
    char_t     rdata;      // Valid the cycle after a granted read

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport target (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface : dbg_mem_if

//--- logic/dbg_reg_formatter.sv
// Captures PC and carry and writes the dump line into the free bank
// Line layout: "PC: " + 5 hex digits + PAD_SPACES spaces + "Carry: x "
module dbg_reg_formatter import saturn_cpu_pkg::*, dbg_text_pkg::*; #(
    parameter int PAD_SPACES = 13
) (
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_start,          // Phase 3 with a decoded instruction
    input  pc_t       i_pc,
    input  logic      i_carry,
    input  logic      i_bank_free,      // Drain has room for another line
    output logic      o_debug_cycle,
    output logic      o_line_done,      // One cycle, line complete in the bank
    output logic      o_line_bank,
    output line_len_t o_line_len,
    dbg_mem_if.requester bus
);

    localparam line_len_t LINE_LEN = line_len_t'(PC_LABEL_LEN + PC_NIBBLES
                                                 + PAD_SPACES + CARRY_FIELD_LEN);

    fmt_state_t state_q;
    line_len_t  pos_q;                  // Position in the line, also the address
    line_len_t  fld_q;                  // Index within the current field
    logic       bank_q;                 // Bank being filled, or filled last
    pc_t        pc_q;                   // Snapshot, shifted left per digit
    logic       carry_q;
    logic       accept;
    logic       wr_ok;
    char_t      wr_char;

    // Nibble to upper-case hex
    function automatic char_t hex_char(input nibble_t d);
        if (d < nibble_t'(10))
            return CH_DIGIT_0 + char_t'(d);
        return CH_HEX_A + char_t'(d - nibble_t'(10));
    endfunction

    // Idle means no line in flight, including the setup cycle after a start
    assign accept = i_start && (state_q == FMT_IDLE) && !o_debug_cycle && i_bank_free;
    assign wr_ok  = bus.req && bus.gnt;

    always_comb begin
        wr_char = CH_SPACE;
        case (state_q)
            FMT_PC_LABEL: begin
                case (fld_q)
                    8'd0:    wr_char = CH_P_UP;
                    8'd1:    wr_char = CH_C_UP;
                    8'd2:    wr_char = CH_COLON;
                    default: wr_char = CH_SPACE;
                endcase
            end
            FMT_PC_DIGITS: wr_char = hex_char(pc_q[PC_W-1 -: NIBBLE_W]); // MSD first
            FMT_CARRY: begin
                case (fld_q)
                    8'd0:    wr_char = CH_C_UP;
                    8'd1:    wr_char = CH_A_LO;
                    8'd2,
                    8'd3:    wr_char = CH_R_LO;
                    8'd4:    wr_char = CH_Y_LO;
                    8'd5:    wr_char = CH_COLON;
                    8'd7:    wr_char = hex_char({3'b000, carry_q});
                    default: wr_char = CH_SPACE;        // Separator and trailing blank
                endcase
            end
            default: wr_char = CH_SPACE;                // Padding
        endcase
    end

    // Every field state is a write, the buffer port is never read from here
    assign bus.req   = (state_q == FMT_PC_LABEL) || (state_q == FMT_PC_DIGITS) ||
                       (state_q == FMT_PAD) || (state_q == FMT_CARRY);
    assign bus.we    = 1'b1;
    assign bus.addr  = {bank_q, pos_q};
    assign bus.wdata = wr_char;

    assign o_line_done = (state_q == FMT_DONE);
    assign o_line_bank = bank_q;
    assign o_line_len  = LINE_LEN;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q       <= FMT_IDLE;
            o_debug_cycle <= 1'b0;
            pos_q         <= '0;
            fld_q         <= '0;
            bank_q        <= 1'b1;              // First line lands in bank 0
        end else begin
            case (state_q)
                FMT_IDLE: begin
                    if (accept) begin
                        o_debug_cycle <= 1'b1;
                        bank_q        <= ~bank_q;       // Other bank than last time
                    end else if (o_debug_cycle) begin
                        state_q <= FMT_PC_LABEL;        // Setup cycle done
                        pos_q   <= '0;
                        fld_q   <= '0;
                    end
                end
                FMT_PC_LABEL, FMT_PC_DIGITS, FMT_PAD, FMT_CARRY: begin
                    if (wr_ok) begin                    // Stall while the port is busy
                        pos_q <= pos_q + 8'd1;
                        fld_q <= fld_q + 8'd1;
                        if (state_q == FMT_PC_LABEL && fld_q == line_len_t'(PC_LABEL_LEN - 1)) begin
                            state_q <= FMT_PC_DIGITS;
                            fld_q   <= '0;
                        end
                        if (state_q == FMT_PC_DIGITS && fld_q == line_len_t'(PC_NIBBLES - 1)) begin
                            state_q <= (PAD_SPACES == 0) ? FMT_CARRY : FMT_PAD;
                            fld_q   <= '0;
                        end
                        if (state_q == FMT_PAD && fld_q == line_len_t'(PAD_SPACES - 1)) begin
                            state_q <= FMT_CARRY;
                            fld_q   <= '0;
                        end
                        if (state_q == FMT_CARRY &&
                            fld_q == line_len_t'(CARRY_FIELD_LEN - 1))
                            state_q <= FMT_DONE;
                    end
                end
                FMT_DONE: begin
                    state_q       <= FMT_IDLE;          // line_done goes out this cycle
                    o_debug_cycle <= 1'b0;
                end
                default: state_q <= FMT_IDLE;
            endcase
        end
    end

    // Snapshot registers, PC shifts one digit per granted digit write
    always_ff @(posedge i_clk) begin
        if (accept) begin
            pc_q    <= i_pc;
            carry_q <= i_carry;
        end else if (state_q == FMT_PC_DIGITS && wr_ok) begin
            pc_q <= pc_q << NIBBLE_W;
        end
    end

endmodule : dbg_reg_formatter

//--- logic/dbg_buf_arbiter.sv
// Shares the single buffer port, formatter has fixed priority over the drain
module dbg_buf_arbiter (
    dbg_mem_if.target    i_fmt,
    dbg_mem_if.target    i_drain,
    dbg_mem_if.requester o_ram
);

    logic fmt_sel;                      // Formatter owns the port this cycle

    assign fmt_sel = i_fmt.req;

    // Winner's fields go straight through to the RAM
    assign o_ram.req   = i_fmt.req || i_drain.req;
    assign o_ram.we    = fmt_sel ? i_fmt.we    : i_drain.we;
    assign o_ram.addr  = fmt_sel ? i_fmt.addr  : i_drain.addr;
    assign o_ram.wdata = fmt_sel ? i_fmt.wdata : i_drain.wdata;

    // Zero-latency grants, drain only when the formatter is quiet
    assign i_fmt.gnt   = i_fmt.req && o_ram.gnt;
    assign i_drain.gnt = i_drain.req && !fmt_sel && o_ram.gnt;

    // Read data goes back to both, only the drain ever reads
    assign i_fmt.rdata   = o_ram.rdata;
    assign i_drain.rdata = o_ram.rdata;

endmodule : dbg_buf_arbiter

//--- logic/dbg_text_ram.sv
// Two-bank character buffer with one synchronous port
module dbg_text_ram import dbg_text_pkg::*; (
    input  logic i_clk,
    dbg_mem_if.target bus
);

    localparam int DEPTH = 2 ** DBG_ADDR_W;    // Two banks of 256

    char_t mem [DEPTH];                         // Contents valid only where written
    char_t rdata_q;

    assign bus.gnt   = 1'b1;                    // Single port, never busy
    assign bus.rdata = rdata_q;

    always_ff @(posedge i_clk) begin
        if (bus.req && bus.gnt) begin
            if (bus.we)
                mem[bus.addr] <= bus.wdata;
            else
                rdata_q <= mem[bus.addr];       // One cycle read latency
        end
    end

endmodule : dbg_text_ram

//--- logic/dbg_text_drain.sv
// Sends finished lines from the buffer, one character per tick
module dbg_text_drain import dbg_text_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_line_done,
    input  logic      i_line_bank,
    input  line_len_t i_line_len,
    input  logic      i_char_tick,
    output logic      o_bank_free,
    output char_t     o_char,
    output logic      o_char_valid,
    output logic      o_line_end,
    dbg_mem_if.requester bus
);

    logic      act_vld_q;               // Line being sent
    logic      act_bank_q;
    line_len_t act_len_q;
    logic      pend_vld_q;              // Line waiting behind it
    logic      pend_bank_q;
    line_len_t pend_len_q;
    line_len_t rd_idx_q;                // Next character to read
    logic      rd_req_q;                // Read outstanding, held until granted
    logic      rd_wait_q;               // Data arrives this cycle
    logic      last_q;                  // Arriving data ends the line
    logic      tick_pend_q;             // One remembered tick
    char_t     char_q;
    logic      rd_grant;
    logic      rd_last;
    logic      go;
    logic      fin;

    assign rd_grant = rd_req_q && bus.gnt;
    assign rd_last  = (rd_idx_q == act_len_q - 8'd1);
    assign fin      = rd_grant && rd_last;
    assign go       = act_vld_q && !rd_req_q && (i_char_tick || tick_pend_q);

    assign bus.req   = rd_req_q;
    assign bus.we    = 1'b0;            // Read only
    assign bus.addr  = {act_bank_q, rd_idx_q};
    assign bus.wdata = '0;

    assign o_bank_free  = !pend_vld_q;
    assign o_char_valid = rd_wait_q;
    assign o_line_end   = rd_wait_q && last_q;
    assign o_char       = rd_wait_q ? bus.rdata : char_q;   // Held between pulses

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            act_vld_q   <= 1'b0;
            pend_vld_q  <= 1'b0;
            rd_idx_q    <= '0;
            rd_req_q    <= 1'b0;
            rd_wait_q   <= 1'b0;
            last_q      <= 1'b0;
            tick_pend_q <= 1'b0;
            char_q      <= '0;
        end else begin
            rd_wait_q <= rd_grant;
            if (rd_grant)
                last_q <= rd_last;
            if (rd_wait_q)
                char_q <= bus.rdata;

            // Request handling, a tick during a pending read waits once
            if (go)
                rd_req_q <= 1'b1;
            else if (rd_grant)
                rd_req_q <= 1'b0;

            if (go)
                tick_pend_q <= tick_pend_q && i_char_tick;
            else if (i_char_tick && rd_req_q)
                tick_pend_q <= 1'b1;        // Extra ticks beyond one are dropped
            else if (fin && !pend_vld_q && !i_line_done)
                tick_pend_q <= 1'b0;        // Nothing left to spend it on

            if (rd_grant)
                rd_idx_q <= rd_last ? '0 : rd_idx_q + 8'd1;

            // Line bookkeeping, pending line moves up after the last character
            if (fin) begin
                act_vld_q  <= pend_vld_q || i_line_done;
                pend_vld_q <= 1'b0;
            end else if (i_line_done) begin
                if (act_vld_q)
                    pend_vld_q <= 1'b1;     // Blocks the formatter until drained
                else
                    act_vld_q <= 1'b1;
            end
        end
    end

    // Bank and length payload
    always_ff @(posedge i_clk) begin
        if (fin) begin
            act_bank_q <= pend_vld_q ? pend_bank_q : i_line_bank;
            act_len_q  <= pend_vld_q ? pend_len_q : i_line_len;
        end else if (i_line_done) begin
            if (act_vld_q) begin
                pend_bank_q <= i_line_bank;
                pend_len_q  <= i_line_len;
            end else begin
                act_bank_q <= i_line_bank;
                act_len_q  <= i_line_len;
            end
        end
    end

endmodule : dbg_text_drain

//--- logic/saturn_debugger_top.sv
// Register dump console: formatter and drain share the text buffer
module saturn_debugger_top import saturn_cpu_pkg::*, dbg_text_pkg::*; #(
    parameter int PAD_SPACES = 13       // Gap between PC and carry fields
) (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic [3:0] i_phases,        // One-hot CPU phase
    input  logic       i_instr_decoded,
    input  pc_t        i_pc,
    input  logic       i_carry,
    input  logic       i_char_tick,     // Character pacing
    output logic       o_debug_cycle,
    output char_t      o_char,
    output logic       o_char_valid,
    output logic       o_line_end
);

    logic      line_done;
    logic      line_bank;
    line_len_t line_len;
    logic      bank_free;

    dbg_mem_if fmt_bus ();
    dbg_mem_if drain_bus ();
    dbg_mem_if ram_bus ();

    dbg_reg_formatter #(
        .PAD_SPACES (PAD_SPACES)
    ) u_formatter (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_start       (i_phases[3] & i_instr_decoded),  // Dump at phase 3 only
        .i_pc          (i_pc),
        .i_carry       (i_carry),
        .i_bank_free   (bank_free),
        .o_debug_cycle (o_debug_cycle),
        .o_line_done   (line_done),
        .o_line_bank   (line_bank),
        .o_line_len    (line_len),
        .bus           (fmt_bus.requester)
    );

    dbg_text_drain u_drain (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_line_done  (line_done),
        .i_line_bank  (line_bank),
        .i_line_len   (line_len),
        .i_char_tick  (i_char_tick),
        .o_bank_free  (bank_free),
        .o_char       (o_char),
        .o_char_valid (o_char_valid),
        .o_line_end   (o_line_end),
        .bus          (drain_bus.requester)
    );

    dbg_buf_arbiter u_arbiter (
        .i_fmt   (fmt_bus.target),
        .i_drain (drain_bus.target),
        .o_ram   (ram_bus.requester)
    );

    dbg_text_ram u_ram (
        .i_clk (i_clk),
        .bus   (ram_bus.target)
    );

endmodule : saturn_debugger_top

//--- sim/saturn_debugger_checker.sv
// Protocol assertions on the shared buffer port and the console outputs
module saturn_debugger_checker (
    input logic i_clk,
    input logic i_reset,
    input logic i_fmt_req,
    input logic i_fmt_gnt,
    input logic i_drain_gnt,
    input logic i_char_valid,
    input logic i_line_end,
    input logic i_debug_cycle
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;                 // Read by the testbench summary

    // Only one requester owns the RAM port in a cycle
    grants_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_fmt_gnt && i_drain_gnt))
    else begin
        $error("Formatter and drain granted in the same cycle");
        fail_count++;
    end

    // Formatter has fixed priority, its request never waits
    fmt_request_wins: assert property (@(posedge i_clk) disable iff (i_reset)
        i_fmt_req |-> i_fmt_gnt)
    else begin
        $error("Formatter request not granted");
        fail_count++;
    end

    line_end_with_char: assert property (@(posedge i_clk) disable iff (i_reset)
        i_line_end |-> i_char_valid)
    else begin
        $error("Line end without a valid character");
        fail_count++;
    end

    // No dump survives a reset
    debug_low_after_reset: assert property (@(posedge i_clk)
        i_reset |=> !i_debug_cycle)
    else begin
        $error("Debug cycle flag high after reset");
        fail_count++;
    end

endmodule : saturn_debugger_checker

bind saturn_debugger_top saturn_debugger_checker assert_inst (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_fmt_req     (fmt_bus.req),
    .i_fmt_gnt     (fmt_bus.gnt),
    .i_drain_gnt   (drain_bus.gnt),
    .i_char_valid  (o_char_valid),
    .i_line_end    (o_line_end),
    .i_debug_cycle (o_debug_cycle)
);

//--- sim/saturn_debugger_tb.sv
// Directed tests for the register dump console
module saturn_debugger_tb import saturn_cpu_pkg::*, dbg_text_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 8;
    localparam int PAD_SPACES  = 13;
    localparam int LINE_CHARS  = 9 + PAD_SPACES + 9;     // "PC: xxxxx" + pad + "Carry: x "
    localparam int DEBUG_HIGH  = LINE_CHARS + 2;         // Setup cycle plus done cycle
    localparam int SLOW_TICK   = 20;
    localparam int TOTAL_LINES = 6;                      // Lines sent over all tests
    localparam int WATCHDOG_CYCLES = TOTAL_LINES * DEBUG_HIGH * SLOW_TICK + 2000;

    logic       i_clk = 1'b0;
    logic       i_reset = 1'b1;                          // Held for the first two edges
    logic [3:0] i_phases = 4'b0001;
    logic       i_instr_decoded = 1'b0;
    pc_t        i_pc = '0;
    logic       i_carry = 1'b0;
    logic       i_char_tick = 1'b0;
    logic       o_debug_cycle;
    char_t      o_char;
    logic       o_char_valid;
    logic       o_line_end;

    int    errors = 0;
    int    seed = 77363;
    int    tick_spacing = 0;                             // 0 = no ticks
    int    tick_cnt = 0;
    int    debug_high_cycles = 0;                        // Running count from the monitor
    int    line_base = 0;                                // Lines already checked
    string cur_line = "";
    string lines[$];                                     // Received lines, never trimmed
    string expected_q[$];

    saturn_debugger_top #(
        .PAD_SPACES (PAD_SPACES)
    ) saturn_debugger_inst (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_phases        (i_phases),
        .i_instr_decoded (i_instr_decoded),
        .i_pc            (i_pc),
        .i_carry         (i_carry),
        .i_char_tick     (i_char_tick),
        .o_debug_cycle   (o_debug_cycle),
        .o_char          (o_char),
        .o_char_valid    (o_char_valid),
        .o_line_end      (o_line_end)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // Character pacing, one tick every tick_spacing cycles
    always @(posedge i_clk) begin
        if (tick_spacing == 0) begin
            i_char_tick <= 1'b0;
            tick_cnt    <= 0;
        end else if (tick_cnt >= tick_spacing - 1) begin
            i_char_tick <= 1'b1;
            tick_cnt    <= 0;
        end else begin
            i_char_tick <= 1'b0;
            tick_cnt    <= tick_cnt + 1;
        end
    end

    // Output monitor, sampled mid-cycle
    always @(negedge i_clk) begin
        if (i_reset) begin
            cur_line = "";                               // Partial line is lost
        end else begin
            if (o_debug_cycle)
                debug_high_cycles++;
            if (o_char_valid) begin
                cur_line = $sformatf("%s%c", cur_line, o_char);
                if (o_line_end) begin
                    lines.push_back(cur_line);
                    cur_line = "";
                end
            end
        end
    end

    // Reference line: label, PC most significant digit first, pad, carry field
    function automatic string build_line(input pc_t pc, input logic carry);
        string hex_digits;
        string s;
        hex_digits = "0123456789ABCDEF";
        s = "PC: ";
        for (int d = 4; d >= 0; d--)
            s = $sformatf("%s%c", s, hex_digits[pc[d*4 +: 4]]);
        for (int p = 0; p < PAD_SPACES; p++)
            s = {s, " "};
        s = {s, "Carry: "};
        s = $sformatf("%s%0d ", s, carry);
        return s;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge i_clk);
    endtask

    task automatic set_tick_spacing(input int n);
        @(negedge i_clk);
        tick_spacing = n;
    endtask

    task automatic do_reset();
        @(posedge i_clk);
        i_reset <= 1'b1;
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
    endtask

    // One-cycle phase strobe with the decode flag as given
    task automatic drive_start(input pc_t pc, input logic carry, input logic ph3,
                               input logic dec);
        @(posedge i_clk);
        i_phases        <= ph3 ? 4'b1000 : 4'b0100;
        i_instr_decoded <= dec;
        i_pc            <= pc;
        i_carry         <= carry;
        @(posedge i_clk);
        i_phases        <= 4'b0001;
        i_instr_decoded <= 1'b0;
    endtask

    // Valid start, checks acceptance one cycle later
    task automatic dump(input pc_t pc, input logic carry, input logic accepted);
        drive_start(pc, carry, 1'b1, 1'b1);
        @(negedge i_clk);
        assert (o_debug_cycle == accepted) else begin
            $display("Mismatch o_debug_cycle: got %0h expected %0h", o_debug_cycle, accepted);
            errors++;
        end
        if (accepted)
            expected_q.push_back(build_line(pc, carry));
    endtask

    task automatic wait_formatter_idle(input int max_cycles);
        int n = 0;
        while (o_debug_cycle && n < max_cycles) begin
            @(negedge i_clk);
            n++;
        end
        assert (!o_debug_cycle) else begin
            $display("Formatter still busy after %0d cycles", max_cycles);
            errors++;
        end
    endtask

    task automatic wait_for_lines(input int count, input int max_cycles);
        int n = 0;
        while (lines.size() - line_base < count && n < max_cycles) begin
            @(negedge i_clk);
            n++;
        end
        assert (lines.size() - line_base >= count) else begin
            $display("Only %0d of %0d lines arrived in time", lines.size() - line_base, count);
            errors++;
        end
    endtask

    // Compare new lines against the model, then mark them checked
    task automatic check_lines();
        int    got_n;
        int    n;
        string got;
        string exp;
        got_n = lines.size() - line_base;
        n = (got_n < expected_q.size()) ? got_n : expected_q.size();
        assert (got_n == expected_q.size()) else begin
            $display("Mismatch line count: got %0h expected %0h", got_n, expected_q.size());
            errors++;
        end
        for (int i = 0; i < n; i++) begin
            got = lines[line_base + i];
            exp = expected_q[i];
            assert (got.len() == exp.len()) else begin
                $display("Mismatch line length: got %0h expected %0h", got.len(), exp.len());
                errors++;
            end
            for (int k = 0; k < got.len() && k < exp.len(); k++)
                assert (got[k] == exp[k]) else begin
                    $display("Mismatch o_char line %0d pos %0d: got %02h expected %02h",
                             i, k, got[k], exp[k]);
                    errors++;
                end
        end
        assert (cur_line.len() == 0) else begin
            $display("Unterminated characters left after the last line: %0d", cur_line.len());
            errors++;
        end
        line_base = lines.size();
        expected_q.delete();
    endtask

    // Outputs stay silent for n cycles
    task automatic expect_quiet(input int n);
        repeat (n) begin
            @(negedge i_clk);
            assert (!o_debug_cycle && !o_char_valid && !o_line_end) else begin
                $display("Mismatch quiet outputs: got %0h expected 0",
                         {o_debug_cycle, o_char_valid, o_line_end});
                errors++;
            end
        end
    endtask

    task automatic quiet_after_reset();
        @(negedge i_clk);
        assert (o_char == 8'h00) else begin
            $display("Mismatch o_char: got %02h expected 00", o_char);
            errors++;
        end
        set_tick_spacing(3);
        expect_quiet(60);
        check_lines();                                   // Expects no line at all
    endtask

    task automatic single_dump();
        int start_cnt;
        set_tick_spacing(4);
        start_cnt = debug_high_cycles;
        dump(pc_t'($random(seed)), 1'b1, 1'b1);
        wait_formatter_idle(DEBUG_HIGH + 10);
        assert (debug_high_cycles - start_cnt == DEBUG_HIGH) else begin
            $display("Mismatch o_debug_cycle high cycles: got %0h expected %0h",
                     debug_high_cycles - start_cnt, DEBUG_HIGH);
            errors++;
        end
        wait_for_lines(1, LINE_CHARS * 4 * 2 + 100);
        idle_cycles(40);
        check_lines();
    endtask

    task automatic ignored_starts();
        set_tick_spacing(2);
        drive_start(pc_t'($random(seed)), 1'b0, 1'b1, 1'b0);     // Phase 3, no decode
        expect_quiet(5);
        drive_start(pc_t'($random(seed)), 1'b1, 1'b0, 1'b1);     // Decode, wrong phase
        expect_quiet(40);
        check_lines();
    endtask

    task automatic third_start_blocked();
        int start_cnt;
        set_tick_spacing(SLOW_TICK);
        start_cnt = debug_high_cycles;
        dump(pc_t'($random(seed)), 1'b1, 1'b1);
        wait_formatter_idle(DEBUG_HIGH + 10);
        dump(pc_t'($random(seed)), 1'b0, 1'b1);          // Goes to the drain's pending slot
        wait_formatter_idle(DEBUG_HIGH + 10);
        dump(pc_t'($random(seed)), 1'b1, 1'b0);          // No bank free
        assert (debug_high_cycles - start_cnt == 2 * DEBUG_HIGH) else begin
            $display("Mismatch o_debug_cycle high cycles: got %0h expected %0h",
                     debug_high_cycles - start_cnt, 2 * DEBUG_HIGH);
            errors++;
        end
        wait_for_lines(2, 2 * LINE_CHARS * SLOW_TICK + 200);
        idle_cycles(3 * SLOW_TICK);
        check_lines();
    endtask

    // Ticks every cycle, second dump takes the port away from the drain
    task automatic drain_loses_arbitration();
        set_tick_spacing(1);
        dump(pc_t'($random(seed)), 1'b0, 1'b1);
        wait_formatter_idle(DEBUG_HIGH + 10);
        dump(pc_t'($random(seed)), 1'b1, 1'b1);
        wait_formatter_idle(DEBUG_HIGH + 10);
        wait_for_lines(2, 4 * LINE_CHARS + 200);
        idle_cycles(20);
        check_lines();
    endtask

    task automatic reset_during_dump();
        set_tick_spacing(4);
        dump(pc_t'($random(seed)), 1'b1, 1'b1);
        idle_cycles(10);
        do_reset();
        @(negedge i_clk);
        assert (!o_debug_cycle && !o_char_valid && !o_line_end && o_char == 8'h00) else begin
            $display("Mismatch outputs after reset: got %0h %02h expected 0 00",
                     {o_debug_cycle, o_char_valid, o_line_end}, o_char);
            errors++;
        end
        line_base = lines.size();                        // Aborted dump is not expected
        expected_q.delete();
        dump(pc_t'($random(seed)), 1'b0, 1'b1);
        wait_formatter_idle(DEBUG_HIGH + 10);
        wait_for_lines(1, LINE_CHARS * 4 * 2 + 100);
        idle_cycles(40);
        check_lines();
    endtask

    initial begin
        int total;
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
        quiet_after_reset();
        single_dump();
        ignored_starts();
        third_start_blocked();
        drain_loses_arbitration();
        reset_during_dump();
        idle_cycles(5);
        total = errors + saturn_debugger_inst.assert_inst.fail_count;
        $display("Summary: %0d check errors, %0d assertion errors, %0d lines received",
                 errors, saturn_debugger_inst.assert_inst.fail_count, lines.size());
        if (total == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // Watchdog sized from the slowest pacing over all lines
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule : saturn_debugger_tb

//--- sim.f
logic/saturn_cpu_pkg.sv
logic/dbg_text_pkg.sv
logic/dbg_mem_if.sv
logic/dbg_reg_formatter.sv
logic/dbg_buf_arbiter.sv
logic/dbg_text_ram.sv
logic/dbg_text_drain.sv
logic/saturn_debugger_top.sv
sim/saturn_debugger_checker.sv
sim/saturn_debugger_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the console testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module saturn_debugger_tb -f sim.f \
    -o saturn_debugger_sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/saturn_debugger_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "Regression passed" && exit 0 || exit 1
